//--- hw/hdc_pkg.sv
`default_nettype none

package hdc_pkg;

    // ==================================================
    // sizes
    // ==================================================
    localparam int word_w   = 32;
    localparam int hv_words = 8;
    localparam int hv_dim   = hv_words * word_w;
    localparam int beat_w   = 64;
    localparam int hv_beats = hv_dim / beat_w;
    localparam int strb_w   = beat_w / 8;
    localparam int item_w   = 16;
    localparam int addr_w   = 12;
    localparam int slot_w   = $clog2(hv_words);
    localparam int beat_sel_w = $clog2(hv_beats);

    // register map, byte offsets
    localparam logic [addr_w-1:0] reg_ctrl = 12'h000;
    localparam logic [addr_w-1:0] reg_item = 12'h004;
    localparam logic [1:0]        resp_okay = 2'b00;

    // axi-lite slave states, one-hot on the read side
    localparam logic [3:0] st_idle  = 4'b0000;
    localparam logic [3:0] st_addr  = 4'b0001;
    localparam logic [3:0] st_wdata = 4'b0010;
    localparam logic [3:0] st_resp  = 4'b0011;
    localparam logic [3:0] st_rd1   = 4'b0100;
    localparam logic [3:0] st_rd2   = 4'b1000;

    // xorshift32 start value and shifts
    localparam logic [word_w-1:0] xs_seed = 32'h2545_F491;
    localparam int xs_shl_a = 13;
    localparam int xs_shr   = 17;
    localparam int xs_shl_b = 5;

    // one hypervector, word 0 and beat 0 at the low end
    typedef union packed {
        logic [hv_words-1:0][word_w-1:0] words;
        logic [hv_beats-1:0][beat_w-1:0] beats;
    } hv_t;

endpackage

`default_nettype wire

//--- hw/axil_regs.sv
`default_nettype none

module axil_regs (
    input  logic                           AXIS_ACLK,
    input  logic                           S_AXI_ARESETN,
    input  logic [31:0]                    s_axi_awaddr,
    input  logic                           s_axi_awvalid,
    output logic                           s_axi_awready,
    input  logic [hdc_pkg::word_w-1:0]     s_axi_wdata,
    input  logic [hdc_pkg::word_w/8-1:0]   s_axi_wstrb,
    input  logic                           s_axi_wvalid,
    output logic                           s_axi_wready,
    output logic [1:0]                     s_axi_bresp,
    output logic                           s_axi_bvalid,
    input  logic                           s_axi_bready,
    input  logic [31:0]                    s_axi_araddr,
    input  logic                           s_axi_arvalid,
    output logic                           s_axi_arready,
    output logic [hdc_pkg::word_w-1:0]     s_axi_rdata,
    output logic [1:0]                     s_axi_rresp,
    output logic                           s_axi_rvalid,
    input  logic                           s_axi_rready,
    input  logic                           item_done,
    output logic                           run,
    output logic                           gen,
    output logic [hdc_pkg::item_w-1:0]     item_num
);
    import hdc_pkg::*;

    logic [3:0]          state;
    logic [addr_w-1:2]   wr_addr;
    logic [addr_w-1:2]   rd_addr;
    logic [word_w-1:0]   wr_data;
    logic [word_w/8-1:0] wr_strb;
    logic                reg_we;
    logic                ctrl_we;
    logic                reg_re;

    // ==================================================
    // handshake
    // ==================================================
    assign s_axi_awready = (state == st_idle) || (state == st_wdata);
    assign s_axi_wready  = (state == st_idle) || (state == st_addr);
    // a read only goes in when no write is offered
    assign s_axi_arready = (state == st_idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == st_resp);
    assign s_axi_rvalid  = (state == st_rd2);
    assign s_axi_bresp   = resp_okay;
    assign s_axi_rresp   = resp_okay;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        state <= st_resp;
                    end else if (s_axi_awvalid) begin
                        state <= st_addr;
                    end else if (s_axi_wvalid) begin
                        state <= st_wdata;
                    end else if (s_axi_arvalid) begin
                        state <= st_rd1;
                    end
                end
                // waiting on the other write phase
                st_addr:  if (s_axi_wvalid) state <= st_resp;
                st_wdata: if (s_axi_awvalid) state <= st_resp;
                st_resp:  if (s_axi_bready) state <= st_idle;
                // rdata is loaded here
                st_rd1:   state <= st_rd2;
                st_rd2:   if (s_axi_rready) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // address and data latches
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            wr_addr <= s_axi_awaddr[addr_w-1:2];
        end
        if (s_axi_wvalid && s_axi_wready) begin
            wr_data <= s_axi_wdata;
            wr_strb <= s_axi_wstrb;
        end
        if (s_axi_arvalid && s_axi_arready) begin
            rd_addr <= s_axi_araddr[addr_w-1:2];
        end
    end

    // ==================================================
    // registers
    // ==================================================
    // single write, on the response handshake
    assign reg_we  = (state == st_resp) && s_axi_bready;
    assign ctrl_we = reg_we && ({wr_addr, 2'b00} == reg_ctrl) && wr_strb[0];
    assign reg_re  = (state == st_rd1);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            run      <= 1'b0;
            gen      <= 1'b0;
            item_num <= '0;
        end else if (ctrl_we) begin
            // bus write beats item_done
            run <= wr_data[1];
            gen <= wr_data[0];
        end else begin
            if (reg_we && ({wr_addr, 2'b00} == reg_item)) begin
                if (wr_strb[0]) item_num[7:0] <= wr_data[7:0];
                if (wr_strb[1]) item_num[15:8] <= wr_data[15:8];
            end
            // generator found the item
            if (item_done) gen <= 1'b0;
        end
    end

    // read mux, unmapped reads zero
    always_ff @(posedge AXIS_ACLK) begin
        if (reg_re) begin
            case ({rd_addr, 2'b00})
                reg_ctrl: s_axi_rdata <= {{(word_w-2){1'b0}}, run, gen};
                reg_item: s_axi_rdata <= {{(word_w-item_w){1'b0}}, item_num};
                default:  s_axi_rdata <= '0;
            endcase
        end
    end

    // write and read responses never overlap
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_bvalid && s_axi_rvalid));

endmodule

`default_nettype wire

//--- hw/item_memory_gen.sv
`default_nettype none

module item_memory_gen (
    input  logic                       AXIS_ACLK,
    input  logic                       S_AXI_ARESETN,
    input  logic                       gen,
    input  logic [hdc_pkg::item_w-1:0] item_num,
    output hdc_pkg::hv_t               hv,
    output logic                       item_done
);
    import hdc_pkg::*;

    logic [word_w-1:0] xs_q;
    logic [word_w-1:0] xs_d;
    logic [slot_w-1:0] slot;
    logic [item_w-1:0] item_cnt;
    logic              item_full;
    logic              hit;
    hv_t               asm_q;

    // ==================================================
    // xorshift32
    // ==================================================
    always_comb begin
        xs_d = xs_q ^ (xs_q << xs_shl_a);
        xs_d = xs_d ^ (xs_d >> xs_shr);
        xs_d = xs_d ^ (xs_d << xs_shl_b);
    end

    // ==================================================
    // counters
    // ==================================================
    // everything parks at seed and zero while gen is low
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            xs_q      <= xs_seed;
            slot      <= '0;
            item_cnt  <= '0;
            item_full <= 1'b0;
            item_done <= 1'b0;
        end else begin
            // one step per cycle
            xs_q      <= xs_d;
            item_full <= (slot == slot_w'(hv_words - 1));
            if (slot == slot_w'(hv_words - 1)) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
            // pulse follows the capture edge
            item_done <= hit;
            if (item_full) begin
                item_cnt <= item_cnt + 1'b1;
            end
        end
    end

    // asm_q holds item item_cnt in full while item_full is set
    assign hit = gen && item_full && (item_cnt == item_num);

    // word assembly
    always_ff @(posedge AXIS_ACLK) begin
        if (gen) begin
            asm_q.words[slot] <= xs_d;
        end
    end

    // capture, held until the next hit
    always_ff @(posedge AXIS_ACLK) begin
        if (hit) begin
            hv <= asm_q;
        end
    end

    // slot index stays inside the vector
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        gen |=> slot < hv_words);

endmodule

`default_nettype wire

//--- hw/hv_streamer.sv
`default_nettype none

module hv_streamer (
    input  logic                       AXIS_ACLK,
    input  logic                       S_AXI_ARESETN,
    input  logic                       run,
    input  hdc_pkg::hv_t               hv,
    input  logic                       m_axis_tready,
    output logic                       m_axis_tvalid,
    output logic [hdc_pkg::beat_w-1:0] m_axis_tdata,
    output logic [hdc_pkg::strb_w-1:0] m_axis_tstrb,
    output logic                       m_axis_tlast
);
    import hdc_pkg::*;

    logic [beat_sel_w-1:0] beat;
    logic                  done;
    logic                  last_beat;

    assign last_beat = (beat == beat_sel_w'(hv_beats - 1));

    // one packet per run, then wait for run to drop
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !run) begin
            beat          <= '0;
            done          <= 1'b0;
            m_axis_tvalid <= 1'b0;
        end else if (!done) begin
            if (!m_axis_tvalid) begin
                m_axis_tvalid <= 1'b1;
            end else if (m_axis_tready) begin
                if (last_beat) begin
                    m_axis_tvalid <= 1'b0;
                    done          <= 1'b1;
                    beat          <= '0;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

    // beat select through the beat view
    assign m_axis_tdata = hv.beats[beat];
    assign m_axis_tlast = m_axis_tvalid && last_beat;
    assign m_axis_tstrb = '1;

    // stalled beat holds, hv must not move under a packet
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata));

endmodule

`default_nettype wire

//--- hw/hdc_top.sv
`default_nettype none

module hdc_top (
    input  logic                         AXIS_ACLK,
    input  logic                         S_AXI_ARESETN,
    // axi4-lite slave
    input  logic [31:0]                  s_axi_awaddr,
    input  logic                         s_axi_awvalid,
    output logic                         s_axi_awready,
    input  logic [hdc_pkg::word_w-1:0]   s_axi_wdata,
    input  logic [hdc_pkg::word_w/8-1:0] s_axi_wstrb,
    input  logic                         s_axi_wvalid,
    output logic                         s_axi_wready,
    output logic [1:0]                   s_axi_bresp,
    output logic                         s_axi_bvalid,
    input  logic                         s_axi_bready,
    input  logic [31:0]                  s_axi_araddr,
    input  logic                         s_axi_arvalid,
    output logic                         s_axi_arready,
    output logic [hdc_pkg::word_w-1:0]   s_axi_rdata,
    output logic [1:0]                   s_axi_rresp,
    output logic                         s_axi_rvalid,
    input  logic                         s_axi_rready,
    // axis master
    output logic                         m_axis_tvalid,
    output logic [hdc_pkg::beat_w-1:0]   m_axis_tdata,
    output logic [hdc_pkg::strb_w-1:0]   m_axis_tstrb,
    output logic                         m_axis_tlast,
    input  logic                         m_axis_tready
);
    import hdc_pkg::*;

    logic              run;
    logic              gen;
    logic              item_done;
    logic [item_w-1:0] item_num;
    hv_t               hv;

    // ==================================================
    // register slave
    // ==================================================
    axil_regs u_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .item_done     (item_done),
        .run           (run),
        .gen           (gen),
        .item_num      (item_num)
    );

    // item memory
    item_memory_gen u_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_num      (item_num),
        .hv            (hv),
        .item_done     (item_done)
    );

    // stream out
    hv_streamer u_stream (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .run           (run),
        .hv            (hv),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tstrb  (m_axis_tstrb),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule

`default_nettype wire

//--- include/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// ==================================================
// reference model
// ==================================================
// one xorshift32 step, 13 / 17 / 5
function automatic logic [31:0] xs_step(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// word w of item n, n*hv_words+w+1 steps from the seed
function automatic logic [31:0] model_word(input int n, input int w);
    logic [31:0] x;
    x = hdc_pkg::xs_seed;
    for (int i = 0; i < n * hdc_pkg::hv_words + w + 1; i++) begin
        x = xs_step(x);
    end
    return x;
endfunction

// register shadow
logic [31:0] shadow_ctrl = '0;
logic [31:0] shadow_item = '0;

// expected read value, gen left out since it clears itself
function automatic logic [31:0] shadow_expect(input logic [31:0] addr);
    if (addr[11:0] == hdc_pkg::reg_ctrl) return shadow_ctrl & 32'h2;
    if (addr[11:0] == hdc_pkg::reg_item) return shadow_item;
    return '0;
endfunction

// ==================================================
// bus tasks, entered 1 unit after a rising edge
// ==================================================
// order 0 both phases together, 1 address first, 2 data first
task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                          input int order, output logic [1:0] resp);
    logic aw_done;
    logic w_done;
    logic aw_hs;
    logic w_hs;
    aw_done = 1'b0;
    w_done  = 1'b0;
    s_axi_awaddr = addr;
    s_axi_wdata  = data;
    s_axi_wstrb  = 4'hf;
    s_axi_bready = 1'b1;
    while (!(aw_done && w_done)) begin
        s_axi_awvalid = !aw_done && (order != 2 || w_done);
        s_axi_wvalid  = !w_done && (order != 1 || aw_done);
        #0;
        aw_hs = s_axi_awvalid && s_axi_awready;
        w_hs  = s_axi_wvalid && s_axi_wready;
        @(posedge AXIS_ACLK);
        #1;
        aw_done = aw_done || aw_hs;
        w_done  = w_done || w_hs;
    end
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    while (!s_axi_bvalid) begin
        @(posedge AXIS_ACLK);
        #1;
    end
    resp = s_axi_bresp;
    @(posedge AXIS_ACLK);
    #1;
    s_axi_bready = 1'b0;
    if (addr[11:0] == hdc_pkg::reg_ctrl) shadow_ctrl = data & 32'h3;
    if (addr[11:0] == hdc_pkg::reg_item) shadow_item = data & 32'hffff;
endtask

task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready  = 1'b1;
    #0;
    while (!s_axi_arready) begin
        @(posedge AXIS_ACLK);
        #1;
    end
    @(posedge AXIS_ACLK);
    #1;
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) begin
        @(posedge AXIS_ACLK);
        #1;
    end
    data = s_axi_rdata;
    resp = s_axi_rresp;
    @(posedge AXIS_ACLK);
    #1;
    s_axi_rready = 1'b0;
endtask

`endif

//--- tb/tb_hdc_top.sv
`default_nettype none

module tb_hdc_top;
    import hdc_pkg::*;

    localparam int rounds   = 6;
    localparam int item_max = 5;
    // whole run budget, in time units
    localparam int wd_time  = (rounds * (item_max + 1) * hv_words + 2000) * 10;

    logic        AXIS_ACLK = 1'b0;
    logic        S_AXI_ARESETN;
    logic [31:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [31:0] s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic        m_axis_tvalid;
    logic [63:0] m_axis_tdata;
    logic [7:0]  m_axis_tstrb;
    logic        m_axis_tlast;
    logic        m_axis_tready;

    integer      seed;
    int          checks = 0;
    int          errors = 0;
    // expected beats of the selected item
    logic [63:0] exp_beat [hv_beats];

    `include "tb_axil_tasks.svh"

    hdc_top DUT (.*);

    // ==================================================
    // clock and watchdog
    // ==================================================
    always #5 AXIS_ACLK = ~AXIS_ACLK;

    initial begin
        #(wd_time);
        $display("watchdog expired before the tests finished, errors so far %0d", errors);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // one packet under random tready, then an idle window
    task automatic receive_packet();
        int          beats;
        int          cycles;
        logic        stalled;
        logic [63:0] held;
        beats   = 0;
        cycles  = 0;
        stalled = 1'b0;
        held    = '0;
        while (beats < hv_beats && cycles < 200) begin
            // a stalled beat must still be there, unchanged
            if (stalled) begin
                check_value("m_axis_tvalid", 64'(m_axis_tvalid), 64'd1);
                check_value("m_axis_tdata", m_axis_tdata, held);
            end
            m_axis_tready = 1'($random(seed));
            if (m_axis_tvalid && m_axis_tready) begin
                check_value("m_axis_tdata", m_axis_tdata, exp_beat[beats]);
                check_value("m_axis_tlast", 64'(m_axis_tlast), 64'(beats == hv_beats - 1));
                check_value("m_axis_tstrb", 64'(m_axis_tstrb), 64'hff);
                beats++;
            end
            stalled = m_axis_tvalid && !m_axis_tready;
            held    = m_axis_tdata;
            @(posedge AXIS_ACLK);
            #1;
            cycles++;
        end
        checks++;
        assert (beats == hv_beats) else begin
            errors++;
            $display("packet incomplete, only %0d beats arrived", beats);
        end
        // nothing more until run toggles
        m_axis_tready = 1'b1;
        repeat (20) begin
            checks++;
            assert (!m_axis_tvalid) else begin
                errors++;
                $display("an extra beat appeared after the packet");
            end
            @(posedge AXIS_ACLK);
            #1;
        end
        m_axis_tready = 1'b0;
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        logic [31:0] rdata;
        logic [1:0]  resp;
        logic [31:0] addr;
        logic [31:0] data;
        int          order;
        int          item;
        int          polls;
        seed          = 32'h992f_7886;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        m_axis_tready = 1'b0;
        repeat (8) @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;

        // reset values
        check_value("m_axis_tvalid", 64'(m_axis_tvalid), 64'd0);
        axil_read(32'(reg_ctrl), rdata, resp);
        check_value("s_axi_rdata", 64'(rdata), 64'd0);
        axil_read(32'(reg_item), rdata, resp);
        check_value("s_axi_rdata", 64'(rdata), 64'd0);

        // item register, phases in random order
        repeat (8) begin
            data  = $random(seed);
            order = $unsigned($random(seed)) % 3;
            axil_write(32'(reg_item), data, order, resp);
            check_value("s_axi_bresp", 64'(resp), 64'(resp_okay));
            axil_read(32'(reg_item), rdata, resp);
            check_value("s_axi_rdata", 64'(rdata), 64'(shadow_expect(32'(reg_item))));
            check_value("s_axi_rresp", 64'(resp), 64'(resp_okay));
        end

        // unmapped offsets, write ignored and read zero
        repeat (4) begin
            addr = $unsigned($random(seed)) & 32'hffc;
            if (addr < 32'h8) addr = addr + 32'h8;
            axil_write(addr, $random(seed), $unsigned($random(seed)) % 3, resp);
            check_value("s_axi_bresp", 64'(resp), 64'(resp_okay));
            axil_read(addr, rdata, resp);
            check_value("s_axi_rdata", 64'(rdata), 64'd0);
            axil_read(32'(reg_item), rdata, resp);
            check_value("s_axi_rdata", 64'(rdata), 64'(shadow_expect(32'(reg_item))));
        end

        // ==================================================
        // generate and stream
        // ==================================================
        for (int r = 0; r < rounds; r++) begin
            item = $unsigned($random(seed)) % (item_max + 1);
            axil_write(32'(reg_item), 32'(item), $unsigned($random(seed)) % 3, resp);
            axil_write(32'(reg_ctrl), 32'h1, 0, resp);
            // wait for gen to drop
            polls = 0;
            rdata = 32'h1;
            while (rdata[0] && polls < 100) begin
                axil_read(32'(reg_ctrl), rdata, resp);
                polls++;
            end
            checks++;
            assert (!rdata[0]) else begin
                errors++;
                $display("gen did not clear after %0d polls for item %0d", polls, item);
            end
            check_value("s_axi_rdata", 64'(rdata), 64'(shadow_expect(32'(reg_ctrl))));

            // beat b is model words 2b and 2b+1
            for (int b = 0; b < hv_beats; b++) begin
                exp_beat[b] = {model_word(item, 2 * b + 1), model_word(item, 2 * b)};
            end

            axil_write(32'(reg_ctrl), 32'h2, 0, resp);
            receive_packet();
            // run again, same packet
            axil_write(32'(reg_ctrl), 32'h0, 0, resp);
            axil_write(32'(reg_ctrl), 32'h2, 0, resp);
            receive_packet();
            axil_write(32'(reg_ctrl), 32'h0, 0, resp);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
hw/hdc_pkg.sv
hw/axil_regs.sv
hw/item_memory_gen.sv
hw/hv_streamer.sv
hw/hdc_top.sv
tb/tb_hdc_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the hdc_top testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_hdc_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_hdc_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the pass line only when every check held
if echo "$out" | grep -Fxq "=== PASS ==="; then
    exit 0
else
    exit 1
fi
